// File: verilog/neuralNet_cfg.svh
`ifndef NEURALNET_CFG_SVH
`define NEURALNET_CFG_SVH

// Network shape.
`define NN_NUM_INPUTS 15
`define NN_NUM_HIDDEN 4
`define NN_NUM_CLASSES 3

// Fixed-point word sizes.
`define NN_ACC_WIDTH 24
`define NN_ACT_WIDTH 8

// Sums above this saturate the activation.
`define NN_SAT_LIMIT 4096

// Low sum bits dropped to form the activation.
`define NN_FRAC_SHIFT 5

`endif

// File: verilog/neuralNetPkg.sv
`include "neuralNet_cfg.svh"

package neuralNetPkg;

	typedef logic [`NN_ACT_WIDTH-1:0] activation_t;
	typedef logic signed [`NN_ACC_WIDTH-1:0] accum_t;
	typedef logic [$clog2(`NN_NUM_CLASSES)-1:0] classIndex_t;

	// Row per neuron, column per input.
	typedef accum_t [0:`NN_NUM_HIDDEN-1][0:`NN_NUM_INPUTS-1] hiddenWeights_t;
	typedef accum_t [0:`NN_NUM_HIDDEN-1] hiddenBias_t;
	typedef accum_t [0:`NN_NUM_CLASSES-1][0:`NN_NUM_HIDDEN-1] outputWeights_t;
	typedef accum_t [0:`NN_NUM_CLASSES-1] outputBias_t;

	// Hidden layer.
	localparam hiddenWeights_t hiddenWeights = '{
		'{ 31,  -3,  -4,  -5,  11,  15,  10,   9,   7,  -5, -20, -21,  -4, -20,  -8},
		'{ 12,   8,  -6,  14,   9,  -2,   5,  17, -11,   6,   3,  -9,  10,   4,  -7},
		'{ -6,  19,   7, -13,   2,   8, -15,   4,  11,  -3,   9,   6, -10,  13,  -5},
		'{  5,  -9,  13,   3, -12,   7,   2,  -4,  -8,  16,   1,  -6,   9,  -3,  -4}
	};

	localparam hiddenBias_t hiddenBias = '{
		3,
		-40,
		25,
		12
	};

	// Output layer.
	localparam outputWeights_t outputWeights = '{
		'{  6,  -2,   4,   3},
		'{ -3,   5,   2,  -1},
		'{  2,   3,  -4,   7}
	};

	localparam outputBias_t outputBias = '{
		10,
		-5,
		30
	};

endpackage

// File: verilog/neuron.sv
`timescale 1ns/1ps
`include "neuralNet_cfg.svh"

module neuron #(
	parameter int NUM_INPUTS = `NN_NUM_INPUTS,
	parameter neuralNetPkg::accum_t [0:NUM_INPUTS-1] WEIGHTS = '0,
	parameter neuralNetPkg::accum_t BIAS = '0
) (
	input  logic clk,
	input  logic reset,
	input  neuralNetPkg::activation_t [NUM_INPUTS-1:0] inputs,
	output neuralNetPkg::activation_t result
);
	import neuralNetPkg::*;

	localparam accum_t satLimit = accum_t'(`NN_SAT_LIMIT);
	localparam int signBit = `NN_ACC_WIDTH - 1;

	activation_t [NUM_INPUTS-1:0] inputReg;
	accum_t [NUM_INPUTS-1:0] products;
	accum_t productSum;
	accum_t sumReg;
	activation_t activation;

	// Stage 1: capture the input vector.
	always_ff @(posedge clk)
	begin
		inputReg <= inputs;
	end

	// Features are zero-extended, products wrap at the accumulator width.
	always_comb
	begin
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			products[i] = accum_t'(inputReg[i]) * WEIGHTS[i];
		end
	end

	always_comb
	begin
		productSum = BIAS;
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			productSum = productSum + products[i];
		end
	end

	// Stage 2: sum plus bias.
	always_ff @(posedge clk)
	begin
		sumReg <= productSum;
	end

	// Rectify, saturate, or take the middle bits.
	always_comb
	begin
		if (sumReg[signBit])
		begin
			activation = '0;
		end
		else if (sumReg > satLimit)
		begin
			activation = '1;
		end
		else
		begin
			activation = sumReg[`NN_FRAC_SHIFT +: `NN_ACT_WIDTH];
		end
	end

	// Stage 3.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result <= activation;
		end
	end

endmodule

// File: verilog/denseLayer.sv
`timescale 1ns/1ps
`include "neuralNet_cfg.svh"

module denseLayer #(
	parameter int NUM_INPUTS = `NN_NUM_INPUTS,
	parameter int NUM_NEURONS = `NN_NUM_HIDDEN,
	parameter neuralNetPkg::accum_t [0:NUM_NEURONS-1][0:NUM_INPUTS-1] WEIGHTS = '0,
	parameter neuralNetPkg::accum_t [0:NUM_NEURONS-1] BIASES = '0
) (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  neuralNetPkg::activation_t [NUM_INPUTS-1:0] inputs,
	output logic outValid,
	output neuralNetPkg::activation_t [NUM_NEURONS-1:0] outputs
);

	// Matches the neuron pipeline depth.
	localparam int latency = 3;

	logic [latency-1:0] validPipe;

	// All neurons see the same vector and move in lockstep.
	genvar n;
	generate
		for (n = 0; n < NUM_NEURONS; n++)
		begin : neuronRow
			neuron #(
				.NUM_INPUTS(NUM_INPUTS),
				.WEIGHTS(WEIGHTS[n]),
				.BIAS(BIASES[n])
			) neuron_inst (
				.clk(clk),
				.reset(reset),
				.inputs(inputs),
				.result(outputs[n])
			);
		end
	endgenerate

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[latency-2:0], inValid};
		end
	end

	assign outValid = validPipe[latency-1];

endmodule

// File: verilog/argmaxSelect.sv
`timescale 1ns/1ps
`include "neuralNet_cfg.svh"

module argmaxSelect #(
	parameter int NUM_SCORES = `NN_NUM_CLASSES
) (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  neuralNetPkg::activation_t [NUM_SCORES-1:0] scores,
	output logic outValid,
	output neuralNetPkg::classIndex_t bestIndex,
	output neuralNetPkg::activation_t [NUM_SCORES-1:0] bestScores
);
	import neuralNetPkg::*;

	classIndex_t scanIndex;
	activation_t scanScore;

	// Strictly greater wins, so ties stay with the lower index.
	always_comb
	begin
		scanIndex = '0;
		scanScore = scores[0];
		for (int i = 1; i < NUM_SCORES; i++)
		begin
			if (scores[i] > scanScore)
			begin
				scanIndex = classIndex_t'(i);
				scanScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= inValid;
		end
	end

	// Result holds until the next vector.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bestIndex <= '0;
			bestScores <= '0;
		end
		else if (inValid)
		begin
			bestIndex <= scanIndex;
			bestScores <= scores;
		end
	end

endmodule

// File: verilog/digitClassifier.sv
`timescale 1ns/1ps
`include "neuralNet_cfg.svh"

module digitClassifier (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  neuralNetPkg::activation_t [`NN_NUM_INPUTS-1:0] features,
	output logic outValid,
	output neuralNetPkg::classIndex_t classIndex,
	output neuralNetPkg::activation_t [`NN_NUM_CLASSES-1:0] classScores
);
	import neuralNetPkg::*;

	logic hiddenValid;
	activation_t [`NN_NUM_HIDDEN-1:0] hiddenActs;

	logic scoreValid;
	activation_t [`NN_NUM_CLASSES-1:0] scores;

	// Features to hidden activations, 3 cycles.
	denseLayer #(
		.NUM_INPUTS(`NN_NUM_INPUTS),
		.NUM_NEURONS(`NN_NUM_HIDDEN),
		.WEIGHTS(hiddenWeights),
		.BIASES(hiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inputs(features),
		.outValid(hiddenValid),
		.outputs(hiddenActs)
	);

	// Hidden activations to class scores, 3 cycles.
	denseLayer #(
		.NUM_INPUTS(`NN_NUM_HIDDEN),
		.NUM_NEURONS(`NN_NUM_CLASSES),
		.WEIGHTS(outputWeights),
		.BIASES(outputBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inputs(hiddenActs),
		.outValid(scoreValid),
		.outputs(scores)
	);

	// Final cycle picks the winner.
	argmaxSelect #(
		.NUM_SCORES(`NN_NUM_CLASSES)
	) argmaxSelect_inst (
		.clk(clk),
		.reset(reset),
		.inValid(scoreValid),
		.scores(scores),
		.outValid(outValid),
		.bestIndex(classIndex),
		.bestScores(classScores)
	);

endmodule

// File: dv/classifierTb.sv
`timescale 1ns/1ps
`include "neuralNet_cfg.svh"

module classifierTb;
	import neuralNetPkg::*;

	typedef struct packed {
		int due;
		int testId;
		logic tie;
		classIndex_t cls;
		activation_t [`NN_NUM_CLASSES-1:0] scores;
	} expect_t;

	localparam int latency = 7;
	localparam int numStrobes = 1 + 3 + 200;
	// Reset and settle, random gaps of up to 3 cycles, and three drains.
	localparam int maxIdle = 5 + 2 + 100 * 3 + 3 * (latency + 4);
	localparam int cycleLimit = numStrobes + maxIdle + latency + 50;

	logic clk;
	logic reset;
	logic inValid;
	activation_t [`NN_NUM_INPUTS-1:0] features;
	logic outValid;
	classIndex_t classIndex;
	activation_t [`NN_NUM_CLASSES-1:0] classScores;

	expect_t expQ[$];
	int cycle = 0;
	int activeTest = 0;
	int checkTest = 0;
	int tieCount = 0;
	int testFails[5] = '{0, 0, 0, 0, 0};
	string testNames[5] = '{"reset", "latency", "activation limits", "pipelining",
		"tie-breaking"};

	logic lastReset = 1'b1;
	logic resetWindow = 1'b1;
	logic expValid = 1'b0;
	int expTest = 0;
	logic expTie = 1'b0;
	classIndex_t expClass = '0;
	activation_t [`NN_NUM_CLASSES-1:0] expScores = '0;

	digitClassifier digitClassifier_inst (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.features(features),
		.outValid(outValid),
		.classIndex(classIndex),
		.classScores(classScores)
	);

	always #20 clk = ~clk;

	// Wrap to the accumulator, then rectify and saturate.
	function automatic activation_t activate(input int sum);
		logic [`NN_ACC_WIDTH-1:0] wrapped;
		int magnitude;
		wrapped = sum[`NN_ACC_WIDTH-1:0];
		magnitude = int'(wrapped);
		if (wrapped[`NN_ACC_WIDTH-1])
			return '0;
		if (magnitude > `NN_SAT_LIMIT)
			return 8'd255;
		return activation_t'(magnitude >> `NN_FRAC_SHIFT);
	endfunction

	function automatic expect_t predict(input activation_t [`NN_NUM_INPUTS-1:0] vec,
		input int testId, input int due);
		activation_t [`NN_NUM_HIDDEN-1:0] hidden;
		int sum;
		int best;
		int ties;
		expect_t e;
		for (int h = 0; h < `NN_NUM_HIDDEN; h++)
		begin
			sum = int'(hiddenBias[h]);
			for (int i = 0; i < `NN_NUM_INPUTS; i++)
				sum = sum + int'(vec[i]) * int'(hiddenWeights[h][i]);
			hidden[h] = activate(sum);
		end
		for (int c = 0; c < `NN_NUM_CLASSES; c++)
		begin
			sum = int'(outputBias[c]);
			for (int h = 0; h < `NN_NUM_HIDDEN; h++)
				sum = sum + int'(hidden[h]) * int'(outputWeights[c][h]);
			e.scores[c] = activate(sum);
		end
		best = 0;
		for (int c = 1; c < `NN_NUM_CLASSES; c++)
			if (e.scores[c] > e.scores[best])
				best = c;
		ties = 0;
		for (int c = 0; c < `NN_NUM_CLASSES; c++)
			if (e.scores[c] == e.scores[best])
				ties++;
		e.due = due;
		e.testId = testId;
		e.tie = (ties > 1);
		e.cls = classIndex_t'(best);
		return e;
	endfunction

	// Called just after a falling edge; the strobe is sampled at the edge ending this cycle.
	task automatic sendVector(input activation_t [`NN_NUM_INPUTS-1:0] vec);
		features = vec;
		inValid = 1'b1;
		expQ.push_back(predict(vec, activeTest, cycle + latency));
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic randomVector(output activation_t [`NN_NUM_INPUTS-1:0] vec,
		input int maxValue);
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			vec[i] = activation_t'($urandom_range(0, maxValue));
	endtask

	task automatic drain();
		inValid = 1'b0;
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	task automatic reportTest(input int id);
		$display("Test %s: %s (%0d errors)", testNames[id],
			(testFails[id] == 0) ? "passed" : "failed", testFails[id]);
	endtask

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles with %0d vectors outstanding.",
				cycle, expQ.size());
			$display("** FAIL **");
			$finish;
		end
	end

	// Expected values for the checks at the following falling edge.
	always @(posedge clk)
	begin : expectStage
		expect_t head;
		lastReset <= reset;
		resetWindow <= reset || lastReset;
		checkTest <= activeTest;
		if (expQ.size() > 0 && expQ[0].due == cycle + 1)
		begin
			head = expQ.pop_front();
			expValid <= 1'b1;
			expTest <= head.testId;
			expTie <= head.tie;
			expClass <= head.cls;
			expScores <= head.scores;
			if (head.tie)
				tieCount <= tieCount + 1;
		end
		else
		begin
			expValid <= 1'b0;
		end
	end

	resetAssert: assert property (@(negedge clk)
		resetWindow |-> (!outValid && classIndex == '0 && classScores == '0))
	else
	begin
		$display("CHECK FAILED reset: expected {outValid,classIndex,classScores}=%h actual %h",
			{1'b0, classIndex_t'(0), {`NN_NUM_CLASSES{8'h00}}},
			{outValid, classIndex, classScores});
		testFails[0]++;
	end

	validAssert: assert property (@(negedge clk) outValid == expValid)
	else
	begin
		$display("CHECK FAILED %s: expected outValid=%0b actual outValid=%0b at cycle %0d",
			testNames[checkTest], expValid, outValid, cycle);
		testFails[checkTest]++;
	end

	scoreAssert: assert property (@(negedge clk)
		(expValid && outValid) |-> classScores == expScores)
	else
	begin
		$display("CHECK FAILED %s: expected classScores=%h actual classScores=%h",
			testNames[expTest], expScores, classScores);
		testFails[expTest]++;
	end

	classAssert: assert property (@(negedge clk)
		(expValid && outValid && !expTie) |-> classIndex == expClass)
	else
	begin
		$display("CHECK FAILED %s: expected classIndex=%0d actual classIndex=%0d",
			testNames[expTest], expClass, classIndex);
		testFails[expTest]++;
	end

	// Equal maxima must resolve to the lowest index.
	tieAssert: assert property (@(negedge clk)
		(expValid && outValid && expTie) |-> classIndex == expClass)
	else
	begin
		$display("CHECK FAILED tie-breaking: expected classIndex=%0d actual classIndex=%0d",
			expClass, classIndex);
		testFails[4]++;
	end

	initial
	begin
		activation_t [`NN_NUM_INPUTS-1:0] vec;
		int failedTests;
		void'($urandom(33));
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		features = '0;

		activeTest = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);
		reportTest(0);

		activeTest = 1;
		sendVector({`NN_NUM_INPUTS{8'h10}});
		drain();
		reportTest(1);

		activeTest = 2;
		sendVector('0);
		sendVector({`NN_NUM_INPUTS{8'hff}});
		// Hidden neuron 0 lands at 3 + 31 * 100, inside the linear range.
		vec = '0;
		vec[0] = 8'd100;
		sendVector(vec);
		drain();
		reportTest(2);

		activeTest = 3;
		for (int n = 0; n < 200; n++)
		begin
			randomVector(vec, (n % 2 == 0) ? 255 : 31);
			sendVector(vec);
			if (n >= 100)
				repeat ($urandom_range(0, 3)) @(negedge clk);
		end
		drain();
		@(posedge clk);
		reportTest(3);

		if (tieCount == 0)
		begin
			$display("Tie-breaking was never exercised: no vector had tied scores.");
			testFails[4]++;
		end
		reportTest(4);

		failedTests = 0;
		for (int t = 0; t < 5; t++)
			if (testFails[t] != 0)
				failedTests++;
		$display("Tests passed: %0d, failed: %0d", 5 - failedTests, failedTests);
		if (failedTests == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+verilog
verilog/neuralNetPkg.sv
verilog/neuron.sv
verilog/denseLayer.sv
verilog/argmaxSelect.sv
verilog/digitClassifier.sv
dv/classifierTb.sv

// File: runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -f vlog.f --top-module classifierTb -Mdir obj_dir

output=$(./obj_dir/VclassifierTb)
echo "$output"

if grep -qxF "** PASS **" <<< "$output"; then
	exit 0
fi
exit 1
